//--- include/mouse_defs.svh
`ifndef MOUSE_DEFS_SVH
`define MOUSE_DEFS_SVH

////////////////////
// address map
////////////////////

// first instruction fetch after reset
`define MOUSE_RST_ADR 32'h0000_0000

// GPR window base, 32 words of 4 bytes
`define MOUSE_GPR_ADR 32'h8000_0000

// low address bits inside the GPR window
// register index sits on [6:2], byte offset on [1:0]
`define MOUSE_GPR_AW 7

`endif

//--- design/mouse_pkg.sv
`default_nettype none

package mouse_pkg;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [31:0] word_t;  // data and address word

  ////////////////////
  // instruction fields
  ////////////////////

  // major opcode, instruction bits [6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00_000,
    OPC_OP_IMM = 5'b00_100,
    OPC_STORE  = 5'b01_000,
    OPC_OP     = 5'b01_100,
    OPC_LUI    = 5'b01_101,
    OPC_JAL    = 5'b11_011
  } opc_t;

  // funct3 of OP and OP_IMM, shifts not implemented
  typedef enum logic [2:0] {
    FN_ADD  = 3'b000,  // SUB on OP with funct7[5]
    FN_SLT  = 3'b010,
    FN_SLTU = 3'b011,
    FN_XOR  = 3'b100,
    FN_OR   = 3'b110,
    FN_AND  = 3'b111
  } alu_fn_t;

  ////////////////////
  // core phases
  ////////////////////

  // each phase names the bus transfer the core is requesting
  typedef enum logic [2:0] {
    PH_FETCH,  // instruction read at next pc
    PH_RS1,    // decode from bus, rs1 read or LUI/JAL rd write
    PH_RS2,    // rs2 read
    PH_EXE,    // ALU result written to rd
    PH_MEM,    // data load or store
    PH_WB,     // load data written to rd
    PH_HALT    // stopped until reset
  } phase_t;

endpackage : mouse_pkg

`default_nettype wire

//--- design/gpr_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_ram import mouse_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       req,
  input  wire logic       wen,
  input  wire logic [4:0] idx,
  input  wire word_t      wdt,
  output word_t           rdt
);

  word_t mem [0:31];  // x0 slot never written

  // write port
  always_ff @(posedge clk) begin
    if (req && wen && (idx != 5'd0)) mem[idx] <= wdt;
  end

  // read data changes only on a read, held across writes and idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdt <= '0;
    end else if (req && !wen) begin
      rdt <= (idx == 5'd0) ? '0 : mem[idx];  // x0 reads zero
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  a_idx_known: assert property (@(posedge clk) disable iff (rst)
    req |-> !$isunknown(idx));

endmodule : gpr_ram

`default_nettype wire

//--- design/bus_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mouse_defs.svh"

module bus_router import mouse_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  // from the core
  input  wire logic       bus_vld,
  input  wire logic       bus_wen,
  input  wire word_t      bus_adr,
  input  wire logic [3:0] bus_ben,
  input  wire word_t      bus_wdt,
  output word_t           bus_rdt,
  output logic            bus_err,
  output logic            bus_rdy,
  // register memory
  output logic            gpr_req,
  output logic            gpr_wen,
  output logic [4:0]      gpr_idx,
  output word_t           gpr_wdt,
  input  wire word_t      gpr_rdt,
  // external port
  output logic            ext_vld,
  output logic            ext_wen,
  output word_t           ext_adr,
  output logic [3:0]      ext_ben,
  output word_t           ext_wdt,
  input  wire word_t      ext_rdt,
  input  wire logic       ext_err,
  input  wire logic       ext_rdy
);

  localparam word_t GPR_ADR = `MOUSE_GPR_ADR;

  logic gpr_hit;  // address inside the register window
  logic sel_ext;  // last transfer went external

  assign gpr_hit = (bus_adr[31:`MOUSE_GPR_AW] == GPR_ADR[31:`MOUSE_GPR_AW]);

  // request side
  assign gpr_req = bus_vld & gpr_hit;
  assign gpr_wen = bus_wen;
  assign gpr_idx = bus_adr[`MOUSE_GPR_AW-1:2];
  assign gpr_wdt = bus_wdt;

  assign ext_vld = bus_vld & ~gpr_hit;
  assign ext_wen = bus_wen;
  assign ext_adr = bus_adr;
  assign ext_ben = bus_ben;
  assign ext_wdt = bus_wdt;

  assign bus_rdy = gpr_hit ? 1'b1 : ext_rdy;  // register memory never stalls

  // response side follows the target of the previous transfer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sel_ext <= 1'b0;
    end else if (bus_vld && bus_rdy) begin
      sel_ext <= ~gpr_hit;
    end
  end

  assign bus_rdt = sel_ext ? ext_rdt : gpr_rdt;
  assign bus_err = sel_ext & ext_err;

  a_one_target: assert property (@(posedge clk) disable iff (rst)
    !(gpr_req && ext_vld));

endmodule : bus_router

`default_nettype wire

//--- design/mouse_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mouse_defs.svh"

module mouse_core import mouse_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  // shared bus for fetch, load/store and GPR access
  output logic            bus_vld,
  output logic            bus_wen,
  output word_t           bus_adr,
  output logic [3:0]      bus_ben,
  output word_t           bus_wdt,
  input  wire word_t      bus_rdt,
  input  wire logic       bus_err,
  input  wire logic       bus_rdy,
  output logic            halt
);

  localparam word_t GPR_ADR = `MOUSE_GPR_ADR;

  // control
  phase_t      phase, ph_nxt;
  logic        run;      // low only in the first cycle out of reset
  logic        bus_trn;  // transfer this cycle
  logic        dec_ok;   // fetched word is a supported instruction
  logic        ill;      // unsupported instruction seen
  word_t       pcr;      // address of the last fetch
  word_t       inw_buf;  // instruction buffer
  word_t       dat_buf;  // rs1 data buffer

  // decoder
  opc_t        bus_opc, dec_opc;
  alu_fn_t     dec_fn3;
  logic [4:0]  bus_rd, bus_rs1, dec_rd, dec_rs2;
  word_t       bus_imu, dec_imi, dec_ims, dec_imj;

  // ALU
  word_t       op1, op2;
  logic        add_sub;  // invert op2 and carry in
  logic        add_sgn;  // sign extend operands for SLT
  logic [32:0] add_sum;
  word_t       log_out, alu_res;

  // register index to GPR window address
  function automatic word_t gpr_adr(input logic [4:0] idx);
    return {GPR_ADR[31:`MOUSE_GPR_AW], idx, 2'b00};
  endfunction

  assign bus_trn = bus_vld & bus_rdy;
  assign bus_ben = 4'b1111;  // word access only
  assign halt    = (phase == PH_HALT);

  ////////////////////
  // decoder
  ////////////////////

  // straight from the bus, valid in PH_RS1
  assign bus_opc = opc_t'(bus_rdt[6:2]);
  assign bus_rd  = bus_rdt[11:7];
  assign bus_rs1 = bus_rdt[19:15];
  assign bus_imu = {bus_rdt[31:12], 12'd0};

  // from the instruction buffer, later phases and next fetch
  assign dec_opc = opc_t'(inw_buf[6:2]);
  assign dec_fn3 = alu_fn_t'(inw_buf[14:12]);
  assign dec_rd  = inw_buf[11:7];
  assign dec_rs2 = inw_buf[24:20];
  assign dec_imi = {{20{inw_buf[31]}}, inw_buf[31:20]};
  assign dec_ims = {{20{inw_buf[31]}}, inw_buf[31:25], inw_buf[11:7]};
  assign dec_imj = {{12{inw_buf[31]}}, inw_buf[19:12], inw_buf[20], inw_buf[30:21], 1'b0};

  always_comb begin
    case (bus_opc)
      OPC_LUI, OPC_JAL:    dec_ok = 1'b1;
      OPC_LOAD, OPC_STORE: dec_ok = (bus_rdt[14:12] == 3'b010);  // LW/SW only
      OPC_OP_IMM, OPC_OP:  dec_ok = (bus_rdt[13:12] != 2'b01);   // no shifts
      default:             dec_ok = 1'b0;
    endcase
  end

  assign ill = (phase == PH_RS1) & ~dec_ok;

  ////////////////////
  // ALU
  ////////////////////

  // operand select, default is pc+4
  always_comb begin
    op1     = pcr;
    op2     = 32'd4;
    add_sub = 1'b0;
    case (phase)
      PH_FETCH: begin
        if (dec_opc == OPC_JAL) op2 = dec_imj;  // jump target
      end
      PH_EXE: begin
        if (dec_opc == OPC_OP) begin
          op1 = dat_buf;  // rs1
          op2 = bus_rdt;  // rs2
        end else begin
          op1 = bus_rdt;  // rs1
          op2 = dec_imi;
        end
        add_sub = (dec_fn3 == FN_SLT) || (dec_fn3 == FN_SLTU)
               || ((dec_opc == OPC_OP) && inw_buf[30]);
      end
      PH_MEM: begin
        if (dec_opc == OPC_STORE) begin
          op1 = dat_buf;  // base from rs1 buffer
          op2 = dec_ims;
        end else begin
          op1 = bus_rdt;  // rs1 just read
          op2 = dec_imi;
        end
      end
      default: begin
      end
    endcase
  end

  // bit 32 of a subtraction is the less-than flag
  assign add_sgn = (dec_fn3 == FN_SLT);
  assign add_sum = {add_sgn & op1[31], op1}
                 + ({add_sgn & op2[31], op2} ^ {33{add_sub}})
                 + {32'd0, add_sub};

  always_comb begin
    case (dec_fn3)
      FN_AND:  log_out = op1 & op2;
      FN_OR:   log_out = op1 | op2;
      default: log_out = op1 ^ op2;
    endcase
  end

  always_comb begin
    case (dec_fn3)
      FN_ADD:          alu_res = add_sum[31:0];
      FN_SLT, FN_SLTU: alu_res = {31'd0, add_sum[32]};
      default:         alu_res = log_out;
    endcase
  end

  ////////////////////
  // phase machine
  ////////////////////

  // request stays off on a bus error or a bad opcode
  assign bus_vld = run & (phase != PH_HALT) & ~bus_err & ~ill;

  always_comb begin
    bus_wen = 1'b0;
    bus_adr = add_sum[31:0];
    bus_wdt = '0;
    ph_nxt  = PH_HALT;
    case (phase)
      PH_FETCH: ph_nxt = PH_RS1;
      PH_RS1: begin
        bus_adr = gpr_adr(bus_rs1);
        case (bus_opc)
          OPC_LUI: begin
            bus_wen = 1'b1;
            bus_adr = gpr_adr(bus_rd);
            bus_wdt = bus_imu;
            ph_nxt  = PH_FETCH;
          end
          OPC_JAL: begin
            bus_wen = 1'b1;
            bus_adr = gpr_adr(bus_rd);
            bus_wdt = add_sum[31:0];  // link pc+4
            ph_nxt  = PH_FETCH;
          end
          OPC_OP_IMM:         ph_nxt = PH_EXE;
          OPC_OP, OPC_STORE:  ph_nxt = PH_RS2;
          OPC_LOAD:           ph_nxt = PH_MEM;
          default:            ph_nxt = PH_HALT;
        endcase
      end
      PH_RS2: begin
        bus_adr = gpr_adr(dec_rs2);
        ph_nxt  = (dec_opc == OPC_STORE) ? PH_MEM : PH_EXE;
      end
      PH_EXE: begin
        bus_wen = 1'b1;
        bus_adr = gpr_adr(dec_rd);
        bus_wdt = alu_res;
        ph_nxt  = PH_FETCH;
      end
      PH_MEM: begin
        bus_wen = (dec_opc == OPC_STORE);
        bus_wdt = bus_rdt;  // rs2 for stores
        ph_nxt  = (dec_opc == OPC_STORE) ? PH_FETCH : PH_WB;
      end
      PH_WB: begin
        bus_wen = 1'b1;
        bus_adr = gpr_adr(dec_rd);
        bus_wdt = bus_rdt;  // load data
        ph_nxt  = PH_FETCH;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run     <= 1'b0;
      phase   <= PH_FETCH;
      pcr     <= `MOUSE_RST_ADR;
      inw_buf <= {25'd0, OPC_JAL, 2'b11};  // JAL x0,0 so first fetch hits reset address
    end else begin
      run <= 1'b1;
      if (bus_err || ill) begin
        phase <= PH_HALT;
      end else if (bus_trn) begin
        phase <= ph_nxt;
      end
      if (bus_trn && (phase == PH_FETCH)) pcr <= bus_adr;
      if (bus_trn && (phase == PH_RS1)) inw_buf <= bus_rdt;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_trn && (phase == PH_RS2)) dat_buf <= bus_rdt;  // rs1 kept for OP/SW
  end

  ////////////////////
  // assertions
  ////////////////////

  // stalled request must not move
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    bus_vld && !bus_rdy |=> bus_vld && $stable(bus_wen) && $stable(bus_adr)
                            && $stable(bus_wdt) && $stable(bus_ben));

  // halted core stays quiet until reset
  a_halt_idle: assert property (@(posedge clk) disable iff (rst)
    phase == PH_HALT |=> phase == PH_HALT && !bus_vld);

endmodule : mouse_core

`default_nettype wire

//--- design/mouse_soc.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_soc import mouse_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  output logic            halt,
  // external code and data bus
  output logic            ext_vld,
  output logic            ext_wen,
  output word_t           ext_adr,
  output logic [3:0]      ext_ben,
  output word_t           ext_wdt,
  input  wire word_t      ext_rdt,
  input  wire logic       ext_err,
  input  wire logic       ext_rdy
);

  // core bus
  logic       bus_vld, bus_wen, bus_err, bus_rdy;
  word_t      bus_adr, bus_wdt, bus_rdt;
  logic [3:0] bus_ben;

  // register memory port
  logic       gpr_req, gpr_wen;
  logic [4:0] gpr_idx;
  word_t      gpr_wdt, gpr_rdt;

  mouse_core u_core (
    .clk, .rst,
    .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt,
    .bus_rdt, .bus_err, .bus_rdy,
    .halt
  );

  bus_router u_router (
    .clk, .rst,
    .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt,
    .bus_rdt, .bus_err, .bus_rdy,
    .gpr_req, .gpr_wen, .gpr_idx, .gpr_wdt, .gpr_rdt,
    .ext_vld, .ext_wen, .ext_adr, .ext_ben, .ext_wdt,
    .ext_rdt, .ext_err, .ext_rdy
  );

  gpr_ram u_gpr (
    .clk, .rst,
    .req (gpr_req),
    .wen (gpr_wen),
    .idx (gpr_idx),
    .wdt (gpr_wdt),
    .rdt (gpr_rdt)
  );

endmodule : mouse_soc

`default_nettype wire

//--- tests/mouse_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mouse_defs.svh"

module mouse_tb import mouse_pkg::*; ();

  localparam int    WAIT_MAX = 2000;             // cycles per wait loop
  localparam word_t RST      = `MOUSE_RST_ADR;
  localparam word_t BASE     = 32'h0000_0400;    // data area, held in x1
  localparam word_t GPR_BASE = `MOUSE_GPR_ADR;

  logic       clk, rst, halt;
  logic       ext_vld, ext_wen, ext_err, ext_rdy;
  logic [3:0] ext_ben;
  word_t      ext_adr, ext_wdt, ext_rdt;

  word_t mem [0:1023];                    // external memory, word indexed
  word_t prog [$];                        // program image from RST
  word_t pre_adr [$], pre_dat [$];        // data words placed before a run
  word_t exp_adr [$], exp_dat [$];        // expected external writes
  word_t wr_adr [$], wr_dat [$], rd_adr [$];  // what the bus really did
  logic [3:0] ben_q [$];                  // byte enables of every transfer
  bit    stall_en, err_en;
  word_t err_adr;
  int    errors, n_tests;

  mouse_soc UUT (
    .clk     (clk),
    .rst     (rst),
    .halt    (halt),
    .ext_vld (ext_vld),
    .ext_wen (ext_wen),
    .ext_adr (ext_adr),
    .ext_ben (ext_ben),
    .ext_wdt (ext_wdt),
    .ext_rdt (ext_rdt),
    .ext_err (ext_err),
    .ext_rdy (ext_rdy)
  );

  always #20 clk = ~clk;  // 40 ns

  ////////////////////
  // memory model
  ////////////////////

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      ext_rdt <= '0;
      ext_err <= 1'b0;
      ext_rdy <= 1'b1;
    end else begin
      ext_rdy <= stall_en ? (($urandom % 3) != 0) : 1'b1;  // about one stall in three
      if (ext_vld && ext_rdy) begin
        if (ext_adr[31:`MOUSE_GPR_AW] == GPR_BASE[31:`MOUSE_GPR_AW]) begin
          $display("register window access leaked to the external bus at %h", ext_adr);
          errors++;
        end
        ben_q.push_back(ext_ben);
        ext_err <= err_en && (ext_adr == err_adr);  // err follows like read data
        if (ext_wen) begin
          mem[ext_adr[11:2]] <= ext_wdt;
          wr_adr.push_back(ext_adr);
          wr_dat.push_back(ext_wdt);
        end else begin
          ext_rdt <= mem[ext_adr[11:2]];  // held until the next transfer
          rd_adr.push_back(ext_adr);
        end
      end
    end
  end

  ////////////////////
  // instruction words
  ////////////////////

  function automatic word_t itype(opc_t opc, logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                  logic [11:0] imm);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic word_t rtype(logic sub, alu_fn_t fn, logic [4:0] rd, logic [4:0] rs1,
                                  logic [4:0] rs2);
    return {1'b0, sub, 5'd0, rs2, rs1, fn, rd, OPC_OP, 2'b11};
  endfunction

  function automatic word_t stype(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE, 2'b11};  // sw
  endfunction

  function automatic word_t utype(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI, 2'b11};
  endfunction

  function automatic word_t jtype(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
  endfunction

  function automatic word_t sext(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32 result rules for OP and OP_IMM
  function automatic word_t alu_ref(alu_fn_t fn, logic sub, word_t a, word_t b);
    case (fn)
      FN_ADD:  return sub ? a - b : a + b;
      FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
      FN_XOR:  return a ^ b;
      FN_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_word(input string name, input string what, input word_t exp,
                            input word_t act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s halt: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ben(input string name, input int n, input logic [3:0] exp,
                           input logic [3:0] act);
    if (exp !== act) begin
      $display("FAIL %s transfer %0d ben: expected %b, actual %b", name, n, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // run control
  ////////////////////

  task automatic start_prog();
    prog.delete();
    pre_adr.delete();
    pre_dat.delete();
    exp_adr.delete();
    exp_dat.delete();
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd1, 5'd0, BASE[11:0]));  // x1 = data base
  endtask

  task automatic expect_write(input word_t adr, input word_t dat);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
  endtask

  task automatic load_mem();
    for (int i = 0; i < 1024; i++) mem[i] = 32'h5a00_0000 ^ (i << 2);  // address tagged
    foreach (prog[i]) mem[RST[11:2] + i] = prog[i];
    foreach (pre_adr[i]) mem[pre_adr[i][11:2]] = pre_dat[i];
  endtask

  // reset, run the loaded program, compare writes and halt
  task automatic run_case(input string name, input bit stall, input bit for_halt,
                          input int rd_idx, input word_t rd_exp);
    int errs0;
    int cyc;
    bit done;
    errs0 = errors;
    n_tests++;
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);  // model now idle in reset
    load_mem();
    wr_adr.delete();
    wr_dat.delete();
    rd_adr.delete();
    ben_q.delete();
    stall_en = stall;
    @(posedge clk);
    rst <= 1'b0;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < WAIT_MAX) begin
      @(negedge clk);
      cyc++;
      done = for_halt ? (halt === 1'b1) : (wr_adr.size() >= exp_adr.size());
    end
    if (!done) begin
      $display("%s: timed out after %0d cycles waiting for the core", name, WAIT_MAX);
      errors++;
    end
    repeat (20) @(negedge clk);  // window for stray writes
    check_flag(name, for_halt, halt);
    check_word(name, "write count", exp_adr.size(), wr_adr.size());
    for (int i = 0; i < exp_adr.size() && i < wr_adr.size(); i++) begin
      check_word(name, $sformatf("write %0d address", i), exp_adr[i], wr_adr[i]);
      check_word(name, $sformatf("write %0d data", i), exp_dat[i], wr_dat[i]);
    end
    foreach (ben_q[i]) begin
      check_ben(name, i, 4'b1111, ben_q[i]);  // word access only
    end
    if (rd_idx >= 0 && rd_idx < rd_adr.size()) begin
      check_word(name, $sformatf("read %0d address", rd_idx), rd_exp, rd_adr[rd_idx]);
    end else if (rd_idx >= 0) begin
      $display("%s: external read %0d never happened", name, rd_idx);
      errors++;
    end
    $display("test %-12s done, %0d errors", name, errors - errs0);
  endtask

  ////////////////////
  // tests
  ////////////////////

  // lui + addi constant, stored externally
  task automatic test_const();
    start_prog();
    prog.push_back(utype(5'd2, 20'h12345));
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd2, 5'd2, 12'hfed));
    prog.push_back(stype(5'd2, 5'd1, 12'h03c));
    prog.push_back(jtype(5'd0, 21'd0));  // park
    expect_write(BASE + 32'h3c, {20'h12345, 12'd0} + sext(12'hfed));
    run_case("const", 1'b0, 1'b0, -1, '0);
    run_case("const_stall", 1'b1, 1'b0, -1, '0);
  endtask

  // every OP and OP_IMM function on random operands
  task automatic test_alu();
    logic [19:0] ah, bh;
    logic [11:0] al, bl, imm;
    word_t       a, b, off;
    alu_fn_t     fn;
    logic        sub;
    ah = 20'($urandom);
    al = 12'($urandom);
    bh = 20'($urandom);
    bl = 12'($urandom);
    a  = {ah, 12'd0} + sext(al);
    b  = {bh, 12'd0} + sext(bl);
    start_prog();
    prog.push_back(utype(5'd2, ah));
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd2, 5'd2, al));
    prog.push_back(utype(5'd3, bh));
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd3, 5'd3, bl));
    off = '0;
    for (int k = 0; k < 7; k++) begin
      case (k)
        0, 1:    fn = FN_ADD;  // k 1 is SUB
        2:       fn = FN_SLT;
        3:       fn = FN_SLTU;
        4:       fn = FN_XOR;
        5:       fn = FN_OR;
        default: fn = FN_AND;
      endcase
      sub = (k == 1);
      prog.push_back(rtype(sub, fn, 5'd4, 5'd2, 5'd3));
      prog.push_back(stype(5'd4, 5'd1, off[11:0]));
      expect_write(BASE + off, alu_ref(fn, sub, a, b));
      off += 4;
      if (k != 1) begin  // no SUBI
        imm = 12'($urandom);
        prog.push_back(itype(OPC_OP_IMM, fn, 5'd5, 5'd2, imm));
        prog.push_back(stype(5'd5, 5'd1, off[11:0]));
        expect_write(BASE + off, alu_ref(fn, 1'b0, a, sext(imm)));
        off += 4;
      end
    end
    prog.push_back(jtype(5'd0, 21'd0));
    run_case("alu", 1'b0, 1'b0, -1, '0);
    run_case("alu_stall", 1'b1, 1'b0, -1, '0);
  endtask

  // lw, addi, sw; third external read is the load
  task automatic test_load();
    word_t       val;
    logic [11:0] imm;
    val = $urandom;
    imm = 12'($urandom);
    start_prog();
    prog.push_back(itype(OPC_LOAD, 3'b010, 5'd2, 5'd1, 12'h200));  // lw x2
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd3, 5'd2, imm));
    prog.push_back(stype(5'd3, 5'd1, 12'h008));
    prog.push_back(jtype(5'd0, 21'd0));
    pre_adr.push_back(BASE + 32'h200);
    pre_dat.push_back(val);
    expect_write(BASE + 32'h8, val + sext(imm));
    run_case("load", 1'b0, 1'b0, 2, BASE + 32'h200);
    run_case("load_stall", 1'b1, 1'b0, 2, BASE + 32'h200);
  endtask

  // jal link and target, x0 stays zero
  task automatic test_jal();
    start_prog();
    prog.push_back(jtype(5'd5, 21'd16));  // at RST+4
    repeat (3) prog.push_back(stype(5'd1, 5'd1, 12'h080));  // jumped over
    prog.push_back(stype(5'd5, 5'd1, 12'h000));
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd0, 5'd1, 12'h005));
    prog.push_back(stype(5'd0, 5'd1, 12'h004));
    prog.push_back(jtype(5'd0, 21'd0));
    expect_write(BASE, RST + 32'd4 + 32'd4);  // pc+4 of the jal
    expect_write(BASE + 32'd4, 32'd0);
    run_case("jal", 1'b0, 1'b0, 2, RST + 32'd4 + 32'd16);
  endtask

  // bus error on a fetch, then an unsupported opcode
  task automatic test_halt();
    start_prog();
    prog.push_back(utype(5'd2, 20'habcde));
    prog.push_back(itype(OPC_OP_IMM, FN_ADD, 5'd2, 5'd2, 12'h123));
    prog.push_back(stype(5'd2, 5'd1, 12'h000));
    prog.push_back(stype(5'd2, 5'd1, 12'h004));  // never runs
    prog.push_back(jtype(5'd0, 21'd0));
    expect_write(BASE, 32'habcde123);
    err_en  = 1'b1;
    err_adr = RST + 32'h10;
    run_case("fetch_err", 1'b0, 1'b1, -1, '0);
    err_en  = 1'b0;
    prog[4] = 32'h0000_0073;  // ecall
    run_case("bad_opcode", 1'b0, 1'b1, -1, '0);
  endtask

  initial begin
    void'($urandom(32'h4eb49810));
    clk      = 1'b0;
    rst      = 1'b1;
    ext_rdt  = '0;
    ext_err  = 1'b0;
    ext_rdy  = 1'b1;
    stall_en = 1'b0;
    err_en   = 1'b0;
    err_adr  = '0;
    errors   = 0;
    n_tests  = 0;
    test_const();
    test_alu();
    test_load();
    test_jal();
    test_halt();
    $display("%0d tests run, %0d checks failed", n_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : mouse_tb

`default_nettype wire

//--- flist.f
+incdir+include
design/mouse_pkg.sv
design/gpr_ram.sv
design/bus_router.sv
design/mouse_core.sv
design/mouse_soc.sv
tests/mouse_tb.sv

//--- Bender.yml
package:
  name: mouse_soc

sources:
  - include_dirs:
      - include
    files:
      - design/mouse_pkg.sv
      - design/gpr_ram.sv
      - design/bus_router.sv
      - design/mouse_core.sv
      - design/mouse_soc.sv
      - target: test
        include_dirs:
          - include
        files:
          - tests/mouse_tb.sv
